// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stream fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sim.f --top-module tb_noc_top --Mdir "$BUILD" -o tb_noc_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD/tb_noc_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

# The log decides the result
if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim.f ====
+incdir+verification
src/noc_cfg_pkg.sv
src/noc_lfsr_pkg.sv
src/axis_link_if.sv
src/traffic_master.sv
src/rr_arbiter.sv
src/stream_router.sv
src/noc_top.sv
verification/tb_noc_top.sv

// ==== src/axis_link_if.sv ====
`timescale 1ns/1ns

interface axis_link_if #(
    parameter int DATA_W = noc_cfg_pkg::DATA_W,
    parameter int DEST_W = noc_cfg_pkg::DEST_W
);

    // Level handshake, a transfer happens when tvalid and tready are both high
    logic              tvalid;
    logic [DATA_W-1:0] tdata;
    logic [DEST_W-1:0] tdest;
    logic              tready;

    // Flit source side
    modport master (
        output tvalid,
        output tdata,
        output tdest,
        input  tready
    );

    // Flit sink side
    modport slave (
        input  tvalid,
        input  tdata,
        input  tdest,
        output tready
    );

endinterface

// ==== src/noc_cfg_pkg.sv ====
package noc_cfg_pkg;

    // Flit payload width in bits
    localparam int DATA_W = 128;

    // Masters feeding the router, and router outputs
    localparam int NUM_PORTS = 4;

    // Destination field selects one output port
    localparam int DEST_W = $clog2(NUM_PORTS);

    // Idle cycles a master waits before offering a flit
    localparam int GAP_CYCLES = 8;

endpackage

// ==== src/noc_lfsr_pkg.sv ====
package noc_lfsr_pkg;

    // Base seed for the payload LFSR, master i uses DATA_SEED ^ i
    localparam logic [127:0] DATA_SEED = {16{8'hA5}};

    // Base seed for the destination LFSR, master i uses DEST_SEED + i
    localparam logic [3:0] DEST_SEED = 4'h1;

    // Destination LFSR step
    // Polynomial x^4 + x^3 + 1, shift left with feedback into bit 0
    function automatic logic [3:0] next_dest(input logic [3:0] state);
        return {state[2:0], state[3] ^ state[2]};
    endfunction

    // Payload LFSR step
    // Polynomial x^128 + x^126 + x^101 + x^99 + 1
    function automatic logic [127:0] next_data(input logic [127:0] state);
        logic fb;
        fb = state[127] ^ state[125] ^ state[100] ^ state[98];
        return {state[126:0], fb};
    endfunction

endpackage

// ==== src/noc_top.sv ====
`timescale 1ns/1ns

module noc_top #(
    parameter int GAP = noc_cfg_pkg::GAP_CYCLES
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    output logic [noc_cfg_pkg::NUM_PORTS-1:0]                     out_tvalid,
    output logic [noc_cfg_pkg::NUM_PORTS*noc_cfg_pkg::DATA_W-1:0] out_tdata,
    output logic [noc_cfg_pkg::NUM_PORTS*noc_cfg_pkg::DEST_W-1:0] out_tdest,
    input  logic [noc_cfg_pkg::NUM_PORTS-1:0]                     out_tready
);

    localparam int DATA_W    = noc_cfg_pkg::DATA_W;
    localparam int DEST_W    = noc_cfg_pkg::DEST_W;
    localparam int NUM_PORTS = noc_cfg_pkg::NUM_PORTS;

    // Master to router links
    axis_link_if #(
        .DATA_W(DATA_W),
        .DEST_W(DEST_W)
    ) in_link [NUM_PORTS] ();

    // Router output links, flattened onto the top ports
    axis_link_if #(
        .DATA_W(DATA_W),
        .DEST_W(DEST_W)
    ) out_link [NUM_PORTS] ();

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        // Master i feeds router input i
        traffic_master #(
            .DATA_W   (DATA_W),
            .DEST_W   (DEST_W),
            .GAP      (GAP),
            .MASTER_ID(i)
        ) master_i (
            .clk  (clk),
            .reset(reset),
            .tx   (in_link[i])
        );

        // Output i occupies slice i of each flat bus
        assign out_tvalid[i]                 = out_link[i].tvalid;
        assign out_tdata[i*DATA_W +: DATA_W] = out_link[i].tdata;
        assign out_tdest[i*DEST_W +: DEST_W] = out_link[i].tdest;
        assign out_link[i].tready            = out_tready[i];
    end

    stream_router #(
        .DATA_W   (DATA_W),
        .DEST_W   (DEST_W),
        .NUM_PORTS(NUM_PORTS)
    ) router_i (
        .clk     (clk),
        .reset   (reset),
        .in_link (in_link),
        .out_link(out_link)
    );

endmodule

// ==== src/rr_arbiter.sv ====
`timescale 1ns/1ns

module rr_arbiter #(
    parameter int N = noc_cfg_pkg::NUM_PORTS
) (
    input  logic         clk,
    input  logic         reset,
    input  logic [N-1:0] req,
    input  logic         advance,
    output logic [N-1:0] grant
);

    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    // Input with highest priority this cycle
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] grant_idx;
    logic             found;

    // Search from the pointer and wrap around
    always_comb begin
        int cand;
        grant     = '0;
        grant_idx = ptr;
        found     = 1'b0;
        for (int k = 0; k < N; k++) begin
            cand = (int'(ptr) + k) % N;
            if (!found && req[cand]) begin
                found       = 1'b1;
                grant_idx   = PTR_W'(cand);
                grant[cand] = 1'b1;
            end
        end
    end

    // Pointer moves just past the winner when the grant is used
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr <= '0;
        end else if (advance && found) begin
            ptr <= PTR_W'((int'(grant_idx) + 1) % N);
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else $error("arbiter granted more than one input");

endmodule

// ==== src/stream_router.sv ====
`timescale 1ns/1ns

module stream_router #(
    parameter int DATA_W    = noc_cfg_pkg::DATA_W,
    parameter int DEST_W    = noc_cfg_pkg::DEST_W,
    parameter int NUM_PORTS = noc_cfg_pkg::NUM_PORTS
) (
    input  logic        clk,
    input  logic        reset,
    axis_link_if.slave  in_link  [NUM_PORTS],
    axis_link_if.master out_link [NUM_PORTS]
);

    // Input side, unpacked from the links
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    logic [DATA_W-1:0]    in_data [NUM_PORTS];
    logic [DEST_W-1:0]    in_dest [NUM_PORTS];

    // Indexed by output, one bit per input
    logic [NUM_PORTS-1:0] req   [NUM_PORTS];
    logic [NUM_PORTS-1:0] grant [NUM_PORTS];
    logic [NUM_PORTS-1:0] take  [NUM_PORTS];

    // Same grants seen from the input side, one bit per output
    logic [NUM_PORTS-1:0] take_col [NUM_PORTS];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        assign in_valid[i] = in_link[i].tvalid;
        assign in_data[i]  = in_link[i].tdata;
        assign in_dest[i]  = in_link[i].tdest;

        // An input targets one output, so at most one bit is set
        assign in_ready[i]       = |take_col[i];
        assign in_link[i].tready = in_ready[i];

        // Two outputs must never pull the same flit
        a_single_owner: assert property (
            @(posedge clk) disable iff (reset) $onehot0(take_col[i]))
            else $error("input %0d taken by several outputs", i);
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        logic              can_load;
        logic              out_valid;
        logic              out_ready;
        logic [DATA_W-1:0] out_data;
        logic [DEST_W-1:0] out_dest;
        logic [DATA_W-1:0] sel_data;
        logic [DEST_W-1:0] sel_dest;

        // Destination decode into requests for this output
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_req
            assign req[o][i]      = in_valid[i] && (in_dest[i] == DEST_W'(o));
            assign take_col[i][o] = take[o][i];
        end

        // Register empty or being drained this cycle
        assign can_load = !out_valid || out_ready;

        rr_arbiter #(
            .N(NUM_PORTS)
        ) arb_i (
            .clk    (clk),
            .reset  (reset),
            .req    (req[o]),
            .advance(can_load),
            .grant  (grant[o])
        );

        // Grant only counts when the register can take the flit
        assign take[o] = can_load ? grant[o] : '0;

        // One-hot AND-OR select of the winning flit
        always_comb begin
            sel_data = '0;
            sel_dest = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (grant[o][i]) begin
                    sel_data = sel_data | in_data[i];
                    sel_dest = sel_dest | in_dest[i];
                end
            end
        end

        // Output stage valid
        // a new flit can replace a draining one in the same cycle
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                out_valid <= 1'b0;
            end else if (can_load) begin
                out_valid <= |grant[o];
            end
        end

        // Payload only loads on an accepted grant
        always_ff @(posedge clk) begin
            if (can_load && |grant[o]) begin
                out_data <= sel_data;
                out_dest <= sel_dest;
            end
        end

        assign out_ready          = out_link[o].tready;
        assign out_link[o].tvalid = out_valid;
        assign out_link[o].tdata  = out_data;
        assign out_link[o].tdest  = out_dest;
    end

endmodule

// ==== src/traffic_master.sv ====
`timescale 1ns/1ns

module traffic_master #(
    parameter int DATA_W    = noc_cfg_pkg::DATA_W,
    parameter int DEST_W    = noc_cfg_pkg::DEST_W,
    parameter int GAP       = noc_cfg_pkg::GAP_CYCLES,
    parameter int MASTER_ID = 0
) (
    input  logic        clk,
    input  logic        reset,
    axis_link_if.master tx
);

    // Gap counter only needs to reach GAP-1
    localparam int CNT_W = (GAP > 1) ? $clog2(GAP) : 1;

    // Per-master seeds, both stay non-zero for the four masters
    localparam logic [127:0] DATA_INIT = noc_lfsr_pkg::DATA_SEED ^ 128'(MASTER_ID);
    localparam logic [3:0]   DEST_INIT = 4'(noc_lfsr_pkg::DEST_SEED + MASTER_ID);

    logic [CNT_W-1:0] gap_cnt;
    logic             offer;
    logic             accepted;
    logic [3:0]       dest_state;
    logic [127:0]     data_state;

    assign accepted = offer && tx.tready;

    // Gap timer and valid flag
    // tvalid rises GAP cycles after reset release or after an accepted flit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gap_cnt <= '0;
            offer   <= 1'b0;
        end else if (offer) begin
            if (tx.tready) begin
                // Flit taken, start the next gap
                gap_cnt <= '0;
                offer   <= 1'b0;
            end
        end else if (gap_cnt == CNT_W'(GAP - 1)) begin
            offer <= 1'b1;
        end else begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    // Both LFSRs step once per accepted flit
    // so each master emits a fixed sequence
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dest_state <= DEST_INIT;
            data_state <= DATA_INIT;
        end else if (accepted) begin
            dest_state <= noc_lfsr_pkg::next_dest(dest_state);
            data_state <= noc_lfsr_pkg::next_data(data_state);
        end
    end

    assign tx.tvalid = offer;
    // Low destination bits pick the router output
    assign tx.tdest  = dest_state[DEST_W-1:0];
    assign tx.tdata  = data_state[DATA_W-1:0];

    // Offered flit is held unchanged until the router takes it
    property p_hold_until_taken;
        @(posedge clk) disable iff (reset)
            offer && !tx.tready |=> offer && $stable(tx.tdata) && $stable(tx.tdest);
    endproperty

    a_hold_until_taken: assert property (p_hold_until_taken)
        else $error("master %0d changed an offered flit", MASTER_ID);

endmodule

// ==== verification/noc_checks.svh ====
`ifndef NOC_CHECKS_SVH
`define NOC_CHECKS_SVH

// Expected flits per master, a small window ahead of the DUT
// A master can run ahead on one port while another port is stalled
localparam int WIN = 2 * NUM_PORTS;

logic [DEST_W-1:0] win_dest [NUM_PORTS][WIN];
logic [DATA_W-1:0] win_data [NUM_PORTS][WIN];
logic              win_used [NUM_PORTS][WIN];

// Generator state for the next flit to enter each window
logic [3:0]        gen_dest [NUM_PORTS];
logic [127:0]      gen_data [NUM_PORTS];

// Put the generator's flit into slot k and step both LFSRs
task automatic append_entry(input int m, input int k);
    win_dest[m][k] = gen_dest[m][DEST_W-1:0];
    win_data[m][k] = gen_data[m][DATA_W-1:0];
    win_used[m][k] = 1'b0;
    gen_dest[m]    = noc_lfsr_pkg::next_dest(gen_dest[m]);
    gen_data[m]    = noc_lfsr_pkg::next_data(gen_data[m]);
endtask

// Master m starts from DEST_SEED + m and DATA_SEED ^ m
task automatic init_model();
    for (int m = 0; m < NUM_PORTS; m++) begin
        gen_dest[m] = 4'(noc_lfsr_pkg::DEST_SEED + m);
        gen_data[m] = noc_lfsr_pkg::DATA_SEED ^ 128'(m);
        for (int k = 0; k < WIN; k++) begin
            append_entry(m, k);
        end
    end
endtask

// Drop consumed flits from the front of the window
task automatic shift_window(input int m);
    while (win_used[m][0]) begin
        for (int k = 0; k < WIN - 1; k++) begin
            win_dest[m][k] = win_dest[m][k+1];
            win_data[m][k] = win_data[m][k+1];
            win_used[m][k] = win_used[m][k+1];
        end
        append_entry(m, WIN - 1);
    end
endtask

task automatic check_flit(input int port, input logic [DEST_W-1:0] got_dest,
                          input logic [DEST_W-1:0] exp_dest,
                          input logic [DATA_W-1:0] got_data,
                          input logic [DATA_W-1:0] exp_data, input string what);
    if (got_dest !== exp_dest || got_data !== exp_data) begin
        $display("FAILED %0t: %s on port %0d, dest %0d expected %0d", $time, what, port,
                 got_dest, exp_dest);
        $display("    data %h", got_data);
        $display("    expected %h", exp_data);
        flit_errs++;
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
        $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
        count_errs++;
    end
endtask

// Per master, the next unused flit for this port must be the one seen
// Exactly one master may claim it
task automatic match_flit(input int port, input logic [DEST_W-1:0] got_dest,
                          input logic [DATA_W-1:0] got_data);
    int hits;
    int hit_m;
    int hit_k;
    int idx;
    hits  = 0;
    hit_m = 0;
    hit_k = 0;
    for (int m = 0; m < NUM_PORTS; m++) begin
        idx = -1;
        for (int k = WIN - 1; k >= 0; k--) begin
            if (!win_used[m][k] && win_dest[m][k] == DEST_W'(port)) idx = k;
        end
        if (idx >= 0 && win_data[m][idx] == got_data) begin
            hits++;
            hit_m = m;
            hit_k = idx;
        end
    end
    if (hits == 1) begin
        check_flit(port, got_dest, DEST_W'(port), got_data, win_data[hit_m][hit_k],
                   "routed flit");
        win_used[hit_m][hit_k] = 1'b1;
        shift_window(hit_m);
        matched++;
    end else begin
        $display("Flit on port %0d at %0t was claimed by %0d master sequences instead of one",
                 port, $time, hits);
        unmatched++;
    end
endtask

`endif

// ==== verification/tb_noc_top.sv ====
`timescale 1ns/1ns

module tb_noc_top;

    localparam int DATA_W    = noc_cfg_pkg::DATA_W;
    localparam int DEST_W    = noc_cfg_pkg::DEST_W;
    localparam int NUM_PORTS = noc_cfg_pkg::NUM_PORTS;
    localparam int GAP       = noc_cfg_pkg::GAP_CYCLES;

    // Run length and the back-pressure hold window
    localparam int NUM_FLITS      = 400;
    localparam int HOLD_START     = 150;
    localparam int HOLD_CYCLES    = 200;
    localparam int HOLD_PORT      = 2;
    localparam int RESET_CYCLES   = 4;
    // Outputs must stay idle this long after reset, well inside GAP
    localparam int QUIET_CYCLES   = GAP / 2;
    localparam int TIMEOUT_CYCLES = NUM_FLITS * (GAP + 2) * NUM_PORTS;

    logic                          clk;
    logic                          reset;
    logic [NUM_PORTS-1:0]          out_tvalid;
    logic [NUM_PORTS*DATA_W-1:0]   out_tdata;
    logic [NUM_PORTS*DEST_W-1:0]   out_tdest;
    logic [NUM_PORTS-1:0]          out_tready;

    integer seed;
    int     flit_errs         = 0;
    int     count_errs        = 0;
    int     proto_errs        = 0;
    int     unmatched         = 0;
    int     matched           = 0;
    int     observed          = 0;
    int     held_flits        = 0;
    int     drained_flits     = 0;
    int     cycle_cnt         = 0;
    int     post_reset_cycles = 0;
    logic   hold_active       = 1'b0;
    logic   hold_seen         = 1'b0;
    logic   hold_done         = 1'b0;
    logic   run_done          = 1'b0;

    // Last sample per output, for the stall stability check
    logic [NUM_PORTS-1:0] prev_stall = '0;
    logic [DATA_W-1:0]    prev_data [NUM_PORTS];
    logic [DEST_W-1:0]    prev_dest [NUM_PORTS];
    logic [DATA_W-1:0]    got_data;
    logic [DEST_W-1:0]    got_dest;

    `include "noc_checks.svh"

    noc_top #(
        .GAP(GAP)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .out_tvalid(out_tvalid),
        .out_tdata (out_tdata),
        .out_tdest (out_tdest),
        .out_tready(out_tready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ready about three cycles in four, optionally one port forced low
    task automatic drive_ready(input int blocked_port);
        logic [31:0] r;
        r          = $random(seed);
        out_tready = r[NUM_PORTS-1:0] | r[2*NUM_PORTS-1:NUM_PORTS];
        if (blocked_port >= 0) out_tready[blocked_port] = 1'b0;
    endtask

    // Sample at the falling edge, valid and ready here mean a transfer at the next rise
    always @(negedge clk) begin
        if (!reset) begin
            post_reset_cycles++;
            if (post_reset_cycles <= QUIET_CYCLES && out_tvalid != '0) begin
                $display("Output valid went high %0d cycles after reset release, at %0t",
                         post_reset_cycles, $time);
                proto_errs++;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                got_data = out_tdata[p*DATA_W +: DATA_W];
                got_dest = out_tdest[p*DEST_W +: DEST_W];
                // A stalled flit has to stay put
                if (prev_stall[p]) begin
                    if (!out_tvalid[p]) begin
                        $display("Port %0d dropped valid without a transfer at %0t", p, $time);
                        proto_errs++;
                    end else begin
                        check_flit(p, got_dest, prev_dest[p], got_data, prev_data[p],
                                   "stalled flit changed");
                    end
                end
                if (out_tvalid[p] && out_tready[p]) begin
                    observed++;
                    if (hold_done && p == HOLD_PORT) drained_flits++;
                    match_flit(p, got_dest, got_data);
                end
                // Distinct flits shown on the held port while it is blocked
                if (hold_active && p == HOLD_PORT) begin
                    if (out_tvalid[p] && (!prev_stall[p] || !hold_seen)) held_flits++;
                    hold_seen = 1'b1;
                end
                prev_stall[p] = out_tvalid[p] && !out_tready[p];
                prev_data[p]  = got_data;
                prev_dest[p]  = got_dest;
            end
        end
    end

    initial begin
        seed       = 32'h889d3dd2;
        reset      = 1'b1;
        out_tready = '0;
        init_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;

        // Random back-pressure on all ports
        while (observed < HOLD_START) begin
            @(posedge clk);
            #10;
            drive_ready(-1);
        end

        // One port blocked, its register fills and its sources stall
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            #10;
            drive_ready(HOLD_PORT);
            hold_active = 1'b1;
        end

        // Release, the held flits drain and have to match the model
        while (observed < NUM_FLITS) begin
            @(posedge clk);
            #10;
            hold_active = 1'b0;
            hold_done   = 1'b1;
            drive_ready(-1);
        end

        run_done = 1'b1;
        check_count("flits matched to a master", matched, observed);
        check_count("unmatched flits", unmatched, 0);
        // Only the flit that fills the held register may show up there
        check_count("flits shown on the held port during the hold", held_flits, 1);
        if (drained_flits == 0) begin
            $display("Held port %0d delivered nothing after its release", HOLD_PORT);
            proto_errs++;
        end
        $display("Errors: flit %0d, count %0d, protocol %0d, unmatched %0d",
                 flit_errs, count_errs, proto_errs, unmatched);
        if (flit_errs + count_errs + proto_errs + unmatched == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Run limit scaled from the flit count and the master gap
    initial begin
        while (!run_done && cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        if (!run_done) begin
            $display("Timeout after %0d cycles with %0d of %0d flits seen",
                     cycle_cnt, observed, NUM_FLITS);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule
